// File: common/rv_pkg.sv
package rv_pkg;

    //////////////////////////////
    // Widths and constants
    //////////////////////////////

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_JUMP
    } br_op_e;

    // WB_NONE also marks a slot that writes no register
    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_PC4,
        WB_DATA
    } wb_sel_e;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_REQ,
        MEM_RELEASE
    } mem_state_e;

    //////////////////////////////
    // Stage slots
    //////////////////////////////

    typedef struct packed {
        word_t pc;
        word_t instr;
    } id_state_t;

    typedef struct packed {
        word_t     pc;
        word_t     br_target;
        word_t     a;
        word_t     b;
        word_t     store_data;
        reg_addr_t rd;
        alu_op_e   alu_op;
        br_op_e    br_op;
        wb_sel_e   wb_sel;
        logic      is_load;
        logic      is_store;
    } ex_state_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
        wb_sel_e   wb_sel;
        logic      is_load;
        logic      is_store;
    } mem_state_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     data;
        reg_addr_t rd;
        wb_sel_e   wb_sel;
    } wb_state_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } dmem_cmd_t;

    // Result a later stage offers to the operand muxes
    typedef struct packed {
        logic      wr;
        reg_addr_t rd;
        word_t     value;
    } fwd_src_t;

endpackage

// File: fetch/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              stall,
    input  logic              mem_ready,
    input  logic              redirect,
    input  rv_pkg::word_t     redirect_target,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::id_state_t id_slot
);
    rv_pkg::word_t pc_q;
    // Address whose ROM word is on imem_data this cycle
    rv_pkg::word_t flight_pc;
    logic          flight_valid;

    // While held, the ROM keeps returning the word in flight
    assign imem_addr = (!mem_ready || stall) ? flight_pc : pc_q;

    assign id_slot.pc    = flight_pc;
    assign id_slot.instr = (flight_valid && !redirect) ? imem_data : rv_pkg::NOP_INSTR;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc_q         <= rv_pkg::RESET_PC;
            flight_pc    <= rv_pkg::RESET_PC;
            flight_valid <= 1'b0;
        end else if (mem_ready) begin
            if (redirect) begin
                // Word already requested belongs to the wrong path
                pc_q         <= redirect_target;
                flight_valid <= 1'b0;
            end else if (!stall) begin
                flight_pc    <= pc_q;
                flight_valid <= 1'b1;
                pc_q         <= pc_q + 32'd4;
            end
        end
    end

endmodule

// File: decode/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk_in,
    input  logic              rst_in,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data
);
    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    // x0 always reads as zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: decode/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic              clk_in,
    input  logic              rst_in,
    input  rv_pkg::id_state_t id_slot,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output logic              uses_rs1,
    output logic              uses_rs2,
    output rv_pkg::word_t     imm_operand_b,
    output logic              use_imm,
    output rv_pkg::word_t     pc_operand_a,
    output logic              use_pc,
    input  rv_pkg::word_t     operand_a,
    input  rv_pkg::word_t     operand_b,
    input  rv_pkg::word_t     store_data,
    input  logic              stall,
    input  logic              mem_ready,
    input  logic              redirect,
    output rv_pkg::ex_state_t ex_slot
);
    rv_pkg::id_state_t id_q;
    logic [31:0]       in;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    rv_pkg::word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::br_op_e    br_op;
    rv_pkg::wb_sel_e   wb_sel;
    logic              is_load, is_store;

    // A redirect loads the annulled word from fetch even during a stall
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            id_q <= '{pc: rv_pkg::RESET_PC, instr: rv_pkg::NOP_INSTR};
        end else if (mem_ready && (redirect || !stall)) begin
            id_q <= id_slot;
        end
    end

    assign in     = id_q.instr;
    assign opcode = in[6:0];
    assign funct3 = in[14:12];
    assign rs1    = in[19:15];
    assign rs2    = in[24:20];

    assign imm_i = {{20{in[31]}}, in[31:20]};
    assign imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
    assign imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
    assign imm_u = {in[31:12], 12'b0};
    assign imm_j = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};

    assign pc_operand_a = id_q.pc;

    //////////////////////////////
    // Control decode
    //////////////////////////////

    always_comb begin
        // Anything not matched below stays a NOP
        alu_op        = rv_pkg::ALU_ADD;
        br_op         = rv_pkg::BR_NONE;
        wb_sel        = rv_pkg::WB_NONE;
        is_load       = 1'b0;
        is_store      = 1'b0;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        use_imm       = 1'b0;
        use_pc        = 1'b0;
        imm_operand_b = imm_i;
        case (opcode)
            rv_pkg::OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                wb_sel   = rv_pkg::WB_ALU;
                case (funct3)
                    3'b000: alu_op = in[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: alu_op = rv_pkg::ALU_SLL;
                    3'b010: alu_op = rv_pkg::ALU_SLT;
                    3'b100: alu_op = rv_pkg::ALU_XOR;
                    3'b101: alu_op = in[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: alu_op = rv_pkg::ALU_OR;
                    3'b111: alu_op = rv_pkg::ALU_AND;
                    default: begin
                        uses_rs1 = 1'b0;
                        uses_rs2 = 1'b0;
                        wb_sel   = rv_pkg::WB_NONE;
                    end
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                wb_sel   = rv_pkg::WB_ALU;
                case (funct3)
                    3'b000: alu_op = rv_pkg::ALU_ADD;
                    3'b010: alu_op = rv_pkg::ALU_SLT;
                    3'b100: alu_op = rv_pkg::ALU_XOR;
                    3'b110: alu_op = rv_pkg::ALU_OR;
                    3'b111: alu_op = rv_pkg::ALU_AND;
                    default: begin
                        uses_rs1 = 1'b0;
                        wb_sel   = rv_pkg::WB_NONE;
                    end
                endcase
            end
            rv_pkg::OPC_LUI: begin
                use_imm       = 1'b1;
                imm_operand_b = imm_u;
                alu_op        = rv_pkg::ALU_PASS_B;
                wb_sel        = rv_pkg::WB_ALU;
            end
            rv_pkg::OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    uses_rs1 = 1'b1;
                    use_imm  = 1'b1;
                    is_load  = 1'b1;
                    wb_sel   = rv_pkg::WB_DATA;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    uses_rs1      = 1'b1;
                    uses_rs2      = 1'b1;
                    use_imm       = 1'b1;
                    imm_operand_b = imm_s;
                    is_store      = 1'b1;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case (funct3)
                    3'b000: br_op = rv_pkg::BR_EQ;
                    3'b001: br_op = rv_pkg::BR_NE;
                    3'b100: br_op = rv_pkg::BR_LT;
                    default: begin
                        uses_rs1 = 1'b0;
                        uses_rs2 = 1'b0;
                    end
                endcase
            end
            rv_pkg::OPC_JAL: begin
                // ALU forms the link as pc + 4
                use_pc        = 1'b1;
                use_imm       = 1'b1;
                imm_operand_b = 32'd4;
                br_op         = rv_pkg::BR_JUMP;
                wb_sel        = rv_pkg::WB_PC4;
            end
            default: ;
        endcase
    end

    always_comb begin
        if (stall || redirect) begin
            ex_slot = '0;
        end else begin
            ex_slot.pc         = id_q.pc;
            ex_slot.br_target  = id_q.pc + ((opcode == rv_pkg::OPC_JAL) ? imm_j : imm_b);
            ex_slot.a          = operand_a;
            ex_slot.b          = operand_b;
            ex_slot.store_data = store_data;
            ex_slot.rd         = in[11:7];
            ex_slot.alu_op     = alu_op;
            ex_slot.br_op      = br_op;
            ex_slot.wb_sel     = wb_sel;
            ex_slot.is_load    = is_load;
            ex_slot.is_store   = is_store;
        end
    end

endmodule

// File: source/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard (
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  logic              uses_rs1,
    input  logic              uses_rs2,
    input  rv_pkg::word_t     imm_operand_b,
    input  logic              use_imm,
    input  rv_pkg::word_t     pc_operand_a,
    input  logic              use_pc,
    input  rv_pkg::word_t     rdata1,
    input  rv_pkg::word_t     rdata2,
    input  rv_pkg::fwd_src_t  ex_fwd,
    input  rv_pkg::fwd_src_t  mem_fwd,
    input  rv_pkg::fwd_src_t  wb_fwd,
    input  logic              ex_is_load,
    input  logic              mem_is_load,
    output logic              stall,
    output rv_pkg::word_t     operand_a,
    output rv_pkg::word_t     operand_b,
    output rv_pkg::word_t     store_data
);
    rv_pkg::word_t fwd_rs1, fwd_rs2;

    function automatic logic hit(rv_pkg::fwd_src_t src, rv_pkg::reg_addr_t rs);
        return src.wr && src.rd == rs && rs != '0;
    endfunction

    // Youngest producer wins, then the register file
    function automatic rv_pkg::word_t pick(rv_pkg::reg_addr_t rs, rv_pkg::word_t rdata);
        if (hit(ex_fwd, rs)) return ex_fwd.value;
        if (hit(mem_fwd, rs)) return mem_fwd.value;
        if (hit(wb_fwd, rs)) return wb_fwd.value;
        return rdata;
    endfunction

    function automatic logic load_hit(rv_pkg::reg_addr_t rs);
        return (ex_is_load && hit(ex_fwd, rs)) || (mem_is_load && hit(mem_fwd, rs));
    endfunction

    assign fwd_rs1 = pick(rs1, rdata1);
    assign fwd_rs2 = pick(rs2, rdata2);

    assign stall = (uses_rs1 && load_hit(rs1)) || (uses_rs2 && load_hit(rs2));

    assign operand_a  = use_pc ? pc_operand_a : fwd_rs1;
    assign operand_b  = use_imm ? imm_operand_b : fwd_rs2;
    // Stores take rs2 through the same bypass as the ALU operand
    assign store_data = fwd_rs2;

endmodule

// File: execute/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic               clk_in,
    input  logic               rst_in,
    input  rv_pkg::ex_state_t  ex_slot,
    input  logic               mem_ready,
    output logic               redirect,
    output rv_pkg::word_t      redirect_target,
    output rv_pkg::fwd_src_t   ex_fwd,
    output logic               ex_is_load,
    output rv_pkg::mem_state_t mem_slot
);
    rv_pkg::ex_state_t ex_q;
    rv_pkg::word_t     alu;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ex_q <= '0;
        end else if (mem_ready) begin
            ex_q <= ex_slot;
        end
    end

    //////////////////////////////
    // ALU and branch compare
    //////////////////////////////

    always_comb begin
        case (ex_q.alu_op)
            rv_pkg::ALU_SUB:    alu = ex_q.a - ex_q.b;
            rv_pkg::ALU_AND:    alu = ex_q.a & ex_q.b;
            rv_pkg::ALU_OR:     alu = ex_q.a | ex_q.b;
            rv_pkg::ALU_XOR:    alu = ex_q.a ^ ex_q.b;
            rv_pkg::ALU_SLT:    alu = {31'b0, $signed(ex_q.a) < $signed(ex_q.b)};
            rv_pkg::ALU_SLL:    alu = ex_q.a << ex_q.b[4:0];
            rv_pkg::ALU_SRL:    alu = ex_q.a >> ex_q.b[4:0];
            rv_pkg::ALU_SRA:    alu = $signed(ex_q.a) >>> ex_q.b[4:0];
            rv_pkg::ALU_PASS_B: alu = ex_q.b;
            default:            alu = ex_q.a + ex_q.b;
        endcase
    end

    always_comb begin
        case (ex_q.br_op)
            rv_pkg::BR_EQ:   redirect = ex_q.a == ex_q.b;
            rv_pkg::BR_NE:   redirect = ex_q.a != ex_q.b;
            rv_pkg::BR_LT:   redirect = $signed(ex_q.a) < $signed(ex_q.b);
            rv_pkg::BR_JUMP: redirect = 1'b1;
            default:         redirect = 1'b0;
        endcase
    end

    assign redirect_target = ex_q.br_target;

    assign ex_fwd.wr    = ex_q.wb_sel != rv_pkg::WB_NONE;
    assign ex_fwd.rd    = ex_q.rd;
    assign ex_fwd.value = (ex_q.wb_sel == rv_pkg::WB_PC4) ? ex_q.pc + 32'd4 : alu;
    assign ex_is_load   = ex_q.is_load;

    assign mem_slot = '{pc: ex_q.pc, alu_result: alu, store_data: ex_q.store_data,
                        rd: ex_q.rd, wb_sel: ex_q.wb_sel,
                        is_load: ex_q.is_load, is_store: ex_q.is_store};

endmodule

// File: memory/rv_memory.sv
`timescale 1ns/1ps

module rv_memory (
    input  logic               clk_in,
    input  logic               rst_in,
    input  rv_pkg::mem_state_t mem_slot,
    output logic               dmem_req,
    output rv_pkg::dmem_cmd_t  dmem_cmd,
    input  logic               dmem_ack,
    input  rv_pkg::word_t      dmem_rdata,
    output logic               mem_ready,
    output rv_pkg::fwd_src_t   mem_fwd,
    output rv_pkg::fwd_src_t   wb_fwd,
    output logic               mem_is_load,
    output logic               wr_en,
    output rv_pkg::reg_addr_t  wr_addr,
    output rv_pkg::word_t      wr_data
);
    rv_pkg::mem_state_t mem_q;
    rv_pkg::wb_state_t  wb_q;
    rv_pkg::mem_state_e state;
    rv_pkg::word_t      load_data;
    logic               access;

    assign access = mem_q.is_load || mem_q.is_store;

    //////////////////////////////
    // Data port handshake
    //////////////////////////////

    assign dmem_req = (state == rv_pkg::MEM_REQ);
    assign dmem_cmd = '{addr: mem_q.alu_result, wdata: mem_q.store_data, write: mem_q.is_store};

    always_comb begin
        case (state)
            rv_pkg::MEM_IDLE:    mem_ready = !access;
            rv_pkg::MEM_RELEASE: mem_ready = !dmem_ack;
            default:             mem_ready = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= rv_pkg::MEM_IDLE;
        end else begin
            case (state)
                rv_pkg::MEM_IDLE:    if (access && !dmem_ack) state <= rv_pkg::MEM_REQ;
                rv_pkg::MEM_REQ:     if (dmem_ack) state <= rv_pkg::MEM_RELEASE;
                rv_pkg::MEM_RELEASE: if (!dmem_ack) state <= rv_pkg::MEM_IDLE;
                default:             state <= rv_pkg::MEM_IDLE;
            endcase
        end
    end

    // Read data is only valid while ack is high
    always_ff @(posedge clk_in) begin
        if (state == rv_pkg::MEM_REQ && dmem_ack) begin
            load_data <= dmem_rdata;
        end
    end

    //////////////////////////////
    // MEM and WB slots
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            mem_q <= '0;
            wb_q  <= '0;
        end else if (mem_ready) begin
            mem_q <= mem_slot;
            wb_q  <= '{pc: mem_q.pc, result: mem_q.alu_result, data: load_data,
                       rd: mem_q.rd, wb_sel: mem_q.wb_sel};
        end
    end

    always_comb begin
        case (wb_q.wb_sel)
            rv_pkg::WB_PC4:  wr_data = wb_q.pc + 32'd4;
            rv_pkg::WB_DATA: wr_data = wb_q.data;
            default:         wr_data = wb_q.result;
        endcase
    end

    assign wr_en   = wb_q.wb_sel != rv_pkg::WB_NONE;
    assign wr_addr = wb_q.rd;

    assign mem_fwd.wr    = mem_q.wb_sel != rv_pkg::WB_NONE;
    assign mem_fwd.rd    = mem_q.rd;
    assign mem_fwd.value = (mem_q.wb_sel == rv_pkg::WB_PC4) ? mem_q.pc + 32'd4 : mem_q.alu_result;
    assign mem_is_load   = mem_q.is_load;

    assign wb_fwd = '{wr: wr_en, rd: wr_addr, value: wr_data};

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic              clk_in,
    input  logic              rst_in,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output logic              dmem_req,
    output rv_pkg::dmem_cmd_t dmem_cmd,
    input  logic              dmem_ack,
    input  rv_pkg::word_t     dmem_rdata
);
    rv_pkg::id_state_t  id_slot;
    rv_pkg::ex_state_t  ex_slot;
    rv_pkg::mem_state_t mem_slot;

    rv_pkg::reg_addr_t rs1, rs2, wr_addr;
    logic              uses_rs1, uses_rs2, use_imm, use_pc;
    rv_pkg::word_t     imm_operand_b, pc_operand_a;
    rv_pkg::word_t     rdata1, rdata2, wr_data;
    rv_pkg::word_t     operand_a, operand_b, store_data;
    rv_pkg::word_t     redirect_target;
    logic              stall, mem_ready, redirect, wr_en;
    logic              ex_is_load, mem_is_load;
    rv_pkg::fwd_src_t  ex_fwd, mem_fwd, wb_fwd;

    rv_fetch fetch (
        .clk_in, .rst_in, .stall, .mem_ready, .redirect, .redirect_target,
        .imem_addr, .imem_data, .id_slot
    );

    rv_decode decode (
        .clk_in, .rst_in, .id_slot, .rs1, .rs2, .uses_rs1, .uses_rs2,
        .imm_operand_b, .use_imm, .pc_operand_a, .use_pc,
        .operand_a, .operand_b, .store_data,
        .stall, .mem_ready, .redirect, .ex_slot
    );

    rv_regfile regfile (
        .clk_in, .rst_in, .rs1, .rs2, .rdata1, .rdata2,
        .wr_en, .wr_addr, .wr_data
    );

    rv_hazard hazard (
        .rs1, .rs2, .uses_rs1, .uses_rs2,
        .imm_operand_b, .use_imm, .pc_operand_a, .use_pc,
        .rdata1, .rdata2, .ex_fwd, .mem_fwd, .wb_fwd,
        .ex_is_load, .mem_is_load,
        .stall, .operand_a, .operand_b, .store_data
    );

    rv_execute execute (
        .clk_in, .rst_in, .ex_slot, .mem_ready,
        .redirect, .redirect_target, .ex_fwd, .ex_is_load, .mem_slot
    );

    rv_memory memory (
        .clk_in, .rst_in, .mem_slot,
        .dmem_req, .dmem_cmd, .dmem_ack, .dmem_rdata,
        .mem_ready, .mem_fwd, .wb_fwd, .mem_is_load,
        .wr_en, .wr_addr, .wr_data
    );

endmodule

// File: testbench/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
    input logic              clk_in,
    input logic              rst_in,
    input logic              dmem_req,
    input rv_pkg::dmem_cmd_t dmem_cmd,
    input logic              dmem_ack
);
    // No request leaves reset
    a_req_after_reset: assert property (@(posedge clk_in) rst_in |=> !dmem_req)
        else $error("dmem_req high after reset");

    a_cmd_stable: assert property (@(posedge clk_in) disable iff (rst_in)
        dmem_req && $past(dmem_req) |-> dmem_cmd == $past(dmem_cmd))
        else $error("dmem_cmd changed during request");

    // Request holds until the memory answers
    a_req_held: assert property (@(posedge clk_in) disable iff (rst_in)
        dmem_req && !dmem_ack |=> dmem_req)
        else $error("dmem_req dropped before dmem_ack");

    // Ack seen at the edge that raised the request must have been low
    a_no_early_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(dmem_req) |-> !$past(dmem_ack))
        else $error("dmem_req rose while dmem_ack high");

endmodule

bind rv_core rv_core_assert handshake_check (
    .clk_in, .rst_in, .dmem_req, .dmem_cmd, .dmem_ack
);

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    localparam rv_pkg::word_t DONE_ADDR = 32'h0000_03fc;
    localparam int TEST_CYCLES = 400;
    localparam int RUN_LIMIT   = 3000;

    logic              clk_in, rst_in, dmem_req, dmem_ack;
    rv_pkg::word_t     imem_addr, imem_data, dmem_rdata, fetch_addr, seed;
    rv_pkg::dmem_cmd_t dmem_cmd;
    rv_pkg::word_t     rom [256];
    rv_pkg::word_t     dmem [256];
    rv_pkg::dmem_cmd_t store_q[$];
    rv_pkg::dmem_cmd_t exp_q[$];
    logic [7:0]        slot;
    logic              done, random_ack;
    int                wait_left, prog_len, cycles, errors, tests, failed_tests, errs_before;

    rv_core UUT (
        .clk_in, .rst_in, .imem_addr, .imem_data,
        .dmem_req, .dmem_cmd, .dmem_ack, .dmem_rdata
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    //////////////////////////////
    // Memory models
    //////////////////////////////

    // Address sampled mid-cycle, word returned after the next edge
    always @(negedge clk_in) fetch_addr = imem_addr;

    always @(posedge clk_in) begin
        #1 imem_data = rom[fetch_addr[9:2]];
    end

    always @(posedge clk_in) begin
        #1;
        if (rst_in) begin
            dmem_ack  = 1'b0;
            wait_left = 0;
        end else if (!dmem_ack && dmem_req) begin
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                dmem_ack = 1'b1;
                slot     = dmem_cmd.addr[9:2];
                if (!dmem_cmd.write) begin
                    dmem_rdata = dmem[slot];
                end else if (dmem_cmd.addr == DONE_ADDR) begin
                    done = 1'b1;
                end else begin
                    dmem[slot] = dmem_cmd.wdata;
                    store_q.push_back(dmem_cmd);
                end
            end
        end else if (dmem_ack && !dmem_req) begin
            dmem_ack = 1'b0;
            if (random_ack) begin
                seed      = xorshift(seed);
                wait_left = int'(seed % 4);
            end
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles >= RUN_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic rv_pkg::word_t xorshift(rv_pkg::word_t x);
        rv_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    //////////////////////////////
    // Instruction encoders
    //////////////////////////////

    function automatic rv_pkg::word_t alu_rr(rv_pkg::word_t f7, f3, rd, rs1, rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t alu_ri(rv_pkg::word_t f3, rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic rv_pkg::word_t upper(rv_pkg::word_t rd, imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic rv_pkg::word_t load_word(rv_pkg::word_t rd, rs1, off);
        return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic rv_pkg::word_t store_word(rv_pkg::word_t rs2, rs1, off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::word_t branch(rv_pkg::word_t f3, rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::word_t jump(rv_pkg::word_t rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(rv_pkg::word_t instr);
        rom[prog_len[7:0]] = instr;
        prog_len++;
    endtask

    task automatic expect_store(rv_pkg::word_t addr, rv_pkg::word_t data);
        exp_q.push_back('{addr: addr, wdata: data, write: 1'b1});
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_word(string name, rv_pkg::word_t got, rv_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cmd(string name, rv_pkg::dmem_cmd_t got, rv_pkg::dmem_cmd_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////
    // Test sequencing
    //////////////////////////////

    task automatic start_test(logic random);
        @(posedge clk_in);
        #1 rst_in = 1'b1;
        errs_before = errors;
        random_ack  = random;
        prog_len    = 0;
        done        = 1'b0;
        store_q.delete();
        exp_q.delete();
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]]  = rv_pkg::NOP_INSTR;
            dmem[i[7:0]] = 32'ha5a5_0000 ^ (i * 4);
        end
    endtask

    task automatic run_program(string name);
        int n;
        // Marker store tells the testbench the program reached its end
        emit(store_word(0, 0, DONE_ADDR));
        emit(jump(0, 0));
        repeat (16) @(posedge clk_in);
        #1 rst_in = 1'b0;
        n = 0;
        while (!done && n < TEST_CYCLES) begin
            @(posedge clk_in);
            n++;
        end
        if (!done) begin
            $display("%s: program never reached its final store", name);
            errors++;
        end
        foreach (exp_q[i]) begin
            if (i >= store_q.size()) begin
                $display("%s: store %0d to %h never arrived", name, i, exp_q[i].addr);
                errors++;
            end else begin
                check_cmd("dmem_cmd", store_q[i], exp_q[i]);
            end
        end
        check_word("store_count", 32'(store_q.size()), 32'(exp_q.size()));
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed", name);
            failed_tests++;
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic alu_chain_test(string name, logic random);
        rv_pkg::word_t r [16];
        start_test(random);
        emit(alu_ri(0, 1, 0, -20));
        emit(alu_ri(0, 2, 0, 3));
        emit(alu_rr(0, 0, 3, 1, 2));
        emit(alu_rr(32, 0, 4, 3, 2));
        emit(alu_rr(0, 6, 5, 3, 2));
        emit(alu_rr(0, 1, 6, 2, 2));
        emit(alu_rr(32, 5, 7, 1, 2));
        emit(alu_rr(0, 5, 8, 1, 2));
        emit(alu_rr(0, 2, 9, 1, 2));
        emit(upper(10, 32'h12345));
        emit(alu_ri(6, 10, 10, 32'h678));
        emit(alu_ri(7, 11, 10, 32'hf0));
        emit(alu_ri(4, 12, 11, -1));
        emit(alu_ri(2, 13, 12, 0));
        emit(alu_rr(0, 7, 14, 10, 3));
        emit(alu_rr(0, 4, 15, 14, 6));
        for (int k = 3; k <= 15; k++) begin
            emit(store_word(k, 0, 4 * (k - 3)));
        end
        // RV32I results of the chain above
        r[1]  = -20;
        r[2]  = 3;
        r[3]  = r[1] + r[2];
        r[4]  = r[3] - r[2];
        r[5]  = r[3] | r[2];
        r[6]  = r[2] << r[2][4:0];
        r[7]  = $signed(r[1]) >>> r[2][4:0];
        r[8]  = r[1] >> r[2][4:0];
        r[9]  = ($signed(r[1]) < $signed(r[2])) ? 32'd1 : 32'd0;
        r[10] = 32'h1234_5000 | 32'h678;
        r[11] = r[10] & 32'hf0;
        r[12] = r[11] ^ 32'hffff_ffff;
        r[13] = ($signed(r[12]) < 0) ? 32'd1 : 32'd0;
        r[14] = r[10] & r[3];
        r[15] = r[14] ^ r[6];
        for (int k = 3; k <= 15; k++) begin
            expect_store(4 * (k - 3), r[k[3:0]]);
        end
        run_program(name);
    endtask

    task automatic load_use_test(string name, logic random);
        start_test(random);
        dmem[16] = 32'hcafe_0123;
        dmem[17] = 32'h0000_7ff1;
        dmem[18] = 32'h8000_0004;
        emit(load_word(1, 0, 32'h40));
        emit(alu_ri(0, 2, 1, 1));
        emit(store_word(2, 0, 0));
        emit(load_word(3, 0, 32'h44));
        emit(alu_rr(0, 0, 4, 3, 3));
        emit(store_word(4, 0, 4));
        emit(load_word(5, 0, 32'h48));
        emit(store_word(5, 0, 8));
        expect_store(0, dmem[16] + 1);
        expect_store(4, dmem[17] + dmem[17]);
        expect_store(8, dmem[18]);
        run_program(name);
    endtask

    task automatic branch_test(string name);
        rv_pkg::word_t a, m, n;
        a = 5;
        m = -1;
        n = 32'h11;
        start_test(1'b0);
        emit(alu_ri(0, 1, 0, a));
        emit(alu_ri(0, 2, 0, a));
        emit(alu_ri(0, 3, 0, m));
        emit(alu_ri(0, 7, 0, n));
        emit(branch(0, 1, 2, 12));
        emit(store_word(1, 0, 32'h100));
        emit(store_word(1, 0, 32'h104));
        emit(store_word(7, 0, 0));
        emit(branch(1, 1, 2, 8));
        emit(store_word(2, 0, 4));
        emit(branch(0, 1, 3, 8));
        emit(store_word(3, 0, 8));
        emit(branch(1, 1, 3, 12));
        emit(store_word(1, 0, 32'h108));
        emit(store_word(1, 0, 32'h10c));
        emit(store_word(7, 0, 12));
        emit(branch(4, 3, 1, 8));
        emit(store_word(1, 0, 32'h110));
        emit(store_word(7, 0, 16));
        emit(branch(4, 1, 3, 8));
        emit(store_word(1, 0, 20));
        // BEQ taken, BNE untaken, BEQ untaken, BNE taken, BLT taken, BLT untaken
        if (a != a) expect_store(32'h100, a);
        expect_store(0, n);
        if (a == a) expect_store(4, a);
        if (a != m) expect_store(8, m);
        expect_store(12, n);
        if (!($signed(m) < $signed(a))) expect_store(32'h110, a);
        expect_store(16, n);
        if (!($signed(a) < $signed(m))) expect_store(20, a);
        run_program(name);
    endtask

    task automatic jal_test(string name);
        start_test(1'b0);
        emit(alu_ri(0, 5, 0, 9));
        emit(jump(1, 12));
        emit(store_word(5, 0, 32'h100));
        emit(store_word(5, 0, 32'h104));
        emit(store_word(1, 0, 0));
        emit(alu_ri(0, 0, 0, 77));
        emit(store_word(0, 0, 4));
        // JAL sits at 4, so its link is 8
        expect_store(0, 32'd4 + 32'd4);
        expect_store(4, 0);
        run_program(name);
    endtask

    initial begin
        rst_in     = 1'b1;
        imem_data  = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        fetch_addr = '0;
        seed       = 32'h3a79;
        random_ack = 1'b0;
        done       = 1'b0;
        wait_left  = 0;
        cycles     = 0;
        errors     = 0;
        tests      = 0;
        failed_tests = 0;
        alu_chain_test("alu_chain", 1'b0);
        load_use_test("load_use", 1'b0);
        branch_test("branches");
        jal_test("jal_link");
        alu_chain_test("alu_chain_random_ack", 1'b1);
        load_use_test("load_use_random_ack", 1'b1);
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
common/rv_pkg.sv
fetch/rv_fetch.sv
decode/rv_regfile.sv
decode/rv_decode.sv
source/rv_hazard.sv
execute/rv_execute.sv
memory/rv_memory.sv
source/rv_core.sv
testbench/rv_core_assert.sv
testbench/tb_rv_core.sv

// File: run_sim.sh
#!/bin/bash
# Build with Verilator and run; the run passes only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_rv_core -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^TESTBENCH PASSED$" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
